// File: bench/tb_pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ctrl_params.svh"

module tb_pipe_ctrl import rv_ctrl_pkg::*; ();

	localparam int PTR_W = $clog2(`RAS_DEPTH);
	localparam int RAND_N = 300;
	localparam int WATCHDOG_CYC = 8 + 200 + RAND_N * 3 + 100;
	typedef logic [PTR_W-1:0] ptr_t;

	logic        clk = 1'b0;
	logic        rst_n, pl_flush, pl_stall;
	logic [31:0] instr, pc, ras_target;
	fwd_sel_t    rs1_fwd, rs2_fwd;
	logic        b_type_prediction_en, jalr_prediction_en, pl_stall_inner;
	int          errors = 0;
	int          test_err = 0;
	int          tests = 0;
	int          stall_cycles;

	pipe_ctrl_top DUT (.*);

	always #4 clk = ~clk;

	// Reference model state. Index 0 is ID, 1 EX, 2 MEM, 3 WB.
	logic [4:0]  m_rd [4];
	logic        m_rw [4];
	logic        m_mr [4];
	logic        m_call_id, m_hist_id, m_hist_ex;
	ptr_t        m_ptr;
	logic [31:0] m_stack [`RAS_DEPTH];
	logic        m_valid [`RAS_DEPTH];
	logic [4:0]  m_track;

	instr_word_t w;
	logic [6:0]  op;
	logic [4:0]  c_rs1, c_rs2, c_rd;
	logic        c_rw, c_call, c_ret, c_mv;
	logic [3:0]  h1, h2;
	fwd_sel_t    e_fwd1, e_fwd2;
	logic        e_bpred, e_jpred, e_stall, e_push, e_pop;
	int          e_delta;
	ptr_t        e_top;

	always_comb begin
		w     = instr;
		op    = w.r.opcode;
		c_rs1 = (op == `OP_JAL || op == `OP_LUI) ? `ZERO_REG : w.i.rs1;
		c_rs2 = (op == `OP_OP || op == `OP_STORE || op == `OP_BRANCH) ? w.s.rs2 : `ZERO_REG;
		c_rd  = (op == `OP_STORE) ? w.s.rs2 : ((op == `OP_BRANCH) ? `ZERO_REG : w.r.rd);
		c_rw  = (op == `OP_LOAD || op == `OP_OPIMM || op == `OP_OP || op == `OP_LUI ||
		         op == `OP_JAL || op == `OP_JALR) && (c_rd != `ZERO_REG);
		c_call = (op == `OP_JAL || op == `OP_JALR) && (c_rd == `RA_REG);
		c_ret  = (op == `OP_JALR) && ((c_rs1 == `RA_REG) ||
		         ((m_track != `ZERO_REG) && (c_rs1 == m_track)));
		c_mv   = (op == `OP_OPIMM) && (w.i.funct3 == 3'd0) && (w.i.imm == 12'd0);
		for (int s = 0; s < 4; s++) begin
			h1[s] = m_rw[s] && (m_rd[s] == c_rs1);
			h2[s] = m_rw[s] && (m_rd[s] == c_rs2);
		end
		e_fwd1  = (h1[2] && !m_mr[2]) ? FWD_MEM : (h1[3] ? FWD_WB : FWD_NONE);
		e_fwd2  = (h2[2] && !m_mr[2]) ? FWD_MEM : (h2[3] ? FWD_WB : FWD_NONE);
		e_bpred = (op == `OP_BRANCH) && (h1[0] || h2[0] || h1[1] || h2[1] ||
		          ((h1[2] || h2[2]) && m_mr[2]));
		e_jpred = c_ret && (h1[0] || h1[1] || (h1[2] && m_mr[2]));
		e_stall = (op == `OP_JALR) && !c_ret && ((h1[1] && !m_mr[1]) || (h1[2] && m_mr[2]));
		e_push  = !pl_flush && !pl_stall && !e_stall && c_call;
		e_pop   = !pl_flush && !pl_stall && !e_stall && c_ret;
		e_delta = int'(e_push) - int'(e_pop) - int'(pl_flush && m_call_id) +
		          int'(pl_flush && m_hist_id) + int'(pl_flush && m_hist_ex);
		e_top   = m_ptr - ptr_t'(1);
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < 4; s++) begin
				m_rd[s] <= 5'd0;
				m_rw[s] <= 1'b0;
				m_mr[s] <= 1'b0;
			end
			for (int i = 0; i < `RAS_DEPTH; i++)
				m_valid[i] <= 1'b0;
			{m_call_id, m_hist_id, m_hist_ex} <= 3'b000;
			m_ptr   <= '0;
			m_track <= `ZERO_REG;
		end else begin
			if (!pl_stall) begin
				m_rd[0]   <= (pl_flush || e_stall) ? 5'd0 : c_rd;
				m_rw[0]   <= !(pl_flush || e_stall) && c_rw;
				m_mr[0]   <= !(pl_flush || e_stall) && (op == `OP_LOAD);
				m_call_id <= !(pl_flush || e_stall) && c_call;
				m_rd[1]   <= pl_flush ? 5'd0 : m_rd[0];
				m_rw[1]   <= !pl_flush && m_rw[0];
				m_mr[1]   <= !pl_flush && m_mr[0];
				for (int s = 2; s < 4; s++) begin
					m_rd[s] <= m_rd[s-1];
					m_rw[s] <= m_rw[s-1];
					m_mr[s] <= m_mr[s-1];
				end
				m_hist_id <= e_jpred && !pl_flush;
				m_hist_ex <= m_hist_id && !pl_flush;
				m_ptr     <= m_ptr + ptr_t'(e_delta);
				if (c_mv && (c_rs1 == `RA_REG) && (c_rd != `ZERO_REG))
					m_track <= c_rd;
				else if ((op == `OP_STORE) && (c_rd == `RA_REG))
					m_track <= `ZERO_REG;
			end
			if (e_push) begin
				m_stack[m_ptr - ptr_t'(e_pop)] <= pc + 32'd4;
				m_valid[m_ptr - ptr_t'(e_pop)] <= 1'b1;
			end
		end
	end

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		errors++;
	endtask

	// Outputs are read before the edge's register updates land.
	always @(posedge clk) begin
		if (rst_n) begin
			assert (rs1_fwd == e_fwd1 && rs2_fwd == e_fwd2) else report_mismatch("forward select");
			assert (b_type_prediction_en == e_bpred) else report_mismatch("branch predict enable");
			assert (jalr_prediction_en == e_jpred) else report_mismatch("jalr predict enable");
			assert (pl_stall_inner == e_stall) else report_mismatch("inner stall");
			if (m_valid[e_top])
				assert (ras_target == m_stack[e_top]) else report_mismatch("ras_target");
			assert (!(pl_stall_inner && c_ret)) else report_mismatch("stall on a return");
		end
	end

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [4:0] rd,
	                                      input logic [4:0] rs1, input logic [11:0] imm);
		instr_word_t x;
		x = '0;
		x.i.opcode = opc;
		x.i.rd     = rd;
		x.i.rs1    = rs1;
		x.i.imm    = imm;
		return x;
	endfunction

	function automatic logic [31:0] enc_rs(input logic [6:0] opc, input logic [4:0] rd,
	                                       input logic [4:0] rs1, input logic [4:0] rs2);
		instr_word_t x;
		x = '0;
		x.r.opcode = opc;
		x.r.rd     = rd; // Lands in the immediate for stores and branches.
		x.r.rs1    = rs1;
		x.r.rs2    = rs2;
		return x;
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd);
		instr_word_t x;
		x = '0;
		x.j.opcode = `OP_JAL;
		x.j.rd     = rd;
		return x;
	endfunction

	localparam logic [31:0] NOP = 32'h0000_0013;

	// Presents one instruction and holds it while the inner stall lasts.
	task automatic issue(input logic [31:0] word, input logic [31:0] addr,
	                     input logic flush = 1'b0, input logic stall = 1'b0);
		int waits;
		waits = 0;
		@(negedge clk);
		instr    = word;
		pc       = addr;
		pl_flush = flush;
		pl_stall = stall;
		#1;
		while (pl_stall_inner) begin
			@(negedge clk);
			pl_flush = 1'b0;
			pl_stall = 1'b0;
			#1;
			waits++;
			if (waits > 16) begin
				$display("jalr stall did not clear within 16 cycles");
				errors++;
				break;
			end
		end
		stall_cycles = waits;
	endtask

	task automatic drain();
		repeat (4) issue(NOP, 32'd0);
	endtask

	task automatic finish_test(input string name);
		$display("test %-12s done, %0d errors", name, errors - test_err);
		test_err = errors;
		tests++;
	endtask

	initial begin
		#(WATCHDOG_CYC * 8);
		$display("watchdog expired before the tests completed");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		int seed;
		int r;
		logic [4:0] a, b, d;
		logic [31:0] word;
		seed = $urandom(80161);
		rst_n = 1'b0;
		instr = NOP;
		pc = 32'd0;
		pl_flush = 1'b0;
		pl_stall = 1'b0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		issue(enc_i(`OP_OPIMM, 5'd5, 5'd0, 12'd1), 32'h0);
		issue(enc_i(`OP_LOAD, 5'd6, 5'd0, 12'd0), 32'h4);
		issue(NOP, 32'h8);
		issue(enc_rs(`OP_OP, 5'd7, 5'd5, 5'd6), 32'hc);
		assert (rs1_fwd == FWD_MEM && rs2_fwd == FWD_NONE) else report_mismatch("MEM forward");
		issue(enc_rs(`OP_OP, 5'd8, 5'd5, 5'd6), 32'h10);
		assert (rs1_fwd == FWD_WB && rs2_fwd == FWD_NONE) else report_mismatch("WB forward");
		drain();
		finish_test("forwarding");

		issue(enc_jal(5'd1), 32'h100);
		issue(NOP, 32'h104);
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h108);
		assert (ras_target == 32'h104) else report_mismatch("call target");
		issue(enc_jal(5'd1), 32'h200);
		issue(enc_jal(5'd1), 32'h300);
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h304);
		assert (ras_target == 32'h304) else report_mismatch("inner return");
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h204);
		assert (ras_target == 32'h204) else report_mismatch("outer return");
		drain();
		finish_test("call_return");

		issue(enc_i(`OP_LOAD, 5'd7, 5'd0, 12'd0), 32'h0);
		repeat (2) issue(NOP, 32'h0);
		issue(enc_i(`OP_JALR, 5'd0, 5'd7, 12'd0), 32'h0);
		assert (stall_cycles == 1) else report_mismatch("load to jalr stall length");
		issue(enc_i(`OP_OPIMM, 5'd7, 5'd0, 12'd4), 32'h0);
		issue(NOP, 32'h0);
		issue(enc_i(`OP_JALR, 5'd0, 5'd7, 12'd0), 32'h0);
		assert (stall_cycles == 1) else report_mismatch("ALU to jalr stall length");
		issue(enc_jal(5'd1), 32'h40);
		issue(NOP, 32'h44);
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h0);
		assert (stall_cycles == 0) else report_mismatch("return stalled");
		drain();
		finish_test("jalr_stall");

		issue(enc_i(`OP_OPIMM, 5'd5, 5'd0, 12'd3), 32'h0);
		issue(enc_rs(`OP_BRANCH, 5'd0, 5'd5, 5'd0), 32'h0);
		assert (b_type_prediction_en) else report_mismatch("branch not predicted");
		drain();
		issue(enc_rs(`OP_BRANCH, 5'd0, 5'd5, 5'd0), 32'h0);
		assert (!b_type_prediction_en) else report_mismatch("branch predicted");
		issue(enc_jal(5'd1), 32'h80);
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h0);
		assert (jalr_prediction_en) else report_mismatch("return not predicted");
		drain();
		finish_test("prediction");

		issue(enc_jal(5'd1), 32'h440);
		drain();
		issue(enc_jal(5'd1), 32'h400);
		issue(NOP, 32'h0, 1'b1);
		drain();
		assert (ras_target == 32'h444) else report_mismatch("call rollback");
		issue(enc_i(`OP_OPIMM, 5'd1, 5'd0, 12'd0), 32'h0);
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h0);
		issue(NOP, 32'h0, 1'b1);
		drain();
		assert (ras_target == 32'h444) else report_mismatch("return rollback in ID");
		issue(enc_i(`OP_OPIMM, 5'd1, 5'd0, 12'd0), 32'h0);
		issue(enc_i(`OP_JALR, 5'd0, 5'd1, 12'd0), 32'h0);
		issue(NOP, 32'h0);
		issue(NOP, 32'h0, 1'b1);
		drain();
		assert (ras_target == 32'h444) else report_mismatch("return rollback in EX");
		issue(enc_jal(5'd1), 32'h480);
		issue(NOP, 32'h0, 1'b1, 1'b1);
		drain();
		assert (ras_target == 32'h484) else report_mismatch("rollback during stall");
		finish_test("flush");

		issue(enc_jal(5'd1), 32'h500);
		issue(enc_i(`OP_OPIMM, 5'd9, 5'd1, 12'd0), 32'h504);
		drain();
		issue(enc_i(`OP_JALR, 5'd0, 5'd9, 12'd0), 32'h0);
		drain();
		assert (ras_target == 32'h484) else report_mismatch("tracked jalr did not pop");
		issue(enc_jal(5'd1), 32'h600);
		issue(enc_rs(`OP_STORE, 5'd0, 5'd0, 5'd1), 32'h604);
		drain();
		issue(enc_i(`OP_JALR, 5'd0, 5'd9, 12'd0), 32'h0);
		drain();
		assert (ras_target == 32'h604) else report_mismatch("untracked jalr popped");
		finish_test("ra_tracking");

		for (int k = 0; k < RAND_N; k++) begin
			r = int'($urandom_range(0, 8));
			a = 5'($urandom_range(0, 9));
			b = 5'($urandom_range(0, 9));
			d = 5'($urandom_range(0, 9));
			case (r)
				0: word = enc_rs(`OP_OP, d, a, b);
				1: word = enc_i(`OP_OPIMM, d, a, 12'd5);
				2: word = enc_i(`OP_LOAD, d, a, 12'd0);
				3: word = enc_rs(`OP_STORE, 5'd0, a, b);
				4: word = enc_rs(`OP_BRANCH, 5'd0, a, b);
				5: word = enc_jal(d);
				6: word = enc_i(`OP_JALR, d, a, 12'd0);
				7: word = enc_i(`OP_OPIMM, d, 5'd1, 12'd0);
				default: word = enc_i(`OP_LUI, d, 5'd0, 12'd0);
			endcase
			issue(word, 32'h1000 + 32'(k) * 32'd4, $urandom_range(0, 15) == 0,
			      $urandom_range(0, 7) == 0);
		end
		drain();
		finish_test("random");

		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/rv_ctrl_pkg.sv
hdl/predecode.sv
hdl/stage_track.sv
hdl/mini_control.sv
hdl/return_stack.sv
hdl/pipe_ctrl_top.sv
bench/tb_pipe_ctrl.sv

// File: hdl/mini_control.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ctrl_params.svh"

module mini_control import rv_ctrl_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [4:0] rs1,
	input  logic [4:0] rs2,
	input  logic [4:0] rd,
	input  logic [4:0] rd_id,
	input  logic [4:0] rd_ex,
	input  logic [4:0] rd_mem,
	input  logic [4:0] rd_wb,
	input  logic       regwrite_id,
	input  logic       regwrite_ex,
	input  logic       regwrite_mem,
	input  logic       regwrite_wb,
	input  logic       memread_ex,
	input  logic       memread_mem,
	input  logic       jal_id,
	input  logic       jalr_id,
	input  logic       b_type,
	input  logic       mv,
	input  logic       sw,
	input  logic       jal,
	input  logic       jalr,
	input  logic       pl_flush,
	input  logic       pl_stall,
	input  logic [4:0] ras_ra_track,
	output fwd_sel_t   rs1_fwd,
	output fwd_sel_t   rs2_fwd,
	output logic       b_type_prediction_en,
	output logic       jalr_prediction_en,
	output logic       pl_stall_inner,
	output logic       ras_push,
	output logic       ras_pop,
	output logic       ras_rollback_pop_id,
	output logic       ras_rollback_push_id,
	output logic       ras_rollback_push_ex,
	output logic       wr_ra_track_en,
	output logic [4:0] wr_ra_track_data
);

	logic rs1_hz_id, rs1_hz_ex, rs1_hz_mem, rs1_hz_wb;
	logic rs2_hz_id, rs2_hz_ex, rs2_hz_mem, rs2_hz_wb;
	logic rs1_hz_ex_noload;
	logic rs1_hz_mem_load, rs1_hz_mem_noload;
	logic rs2_hz_mem_load, rs2_hz_mem_noload;
	logic is_ret;
	logic rd_is_ra;
	logic advance;
	logic pred_hist_id, pred_hist_ex;

	assign rs1_hz_id  = regwrite_id  && (rd_id  == rs1);
	assign rs1_hz_ex  = regwrite_ex  && (rd_ex  == rs1);
	assign rs1_hz_mem = regwrite_mem && (rd_mem == rs1);
	assign rs1_hz_wb  = regwrite_wb  && (rd_wb  == rs1);
	assign rs2_hz_id  = regwrite_id  && (rd_id  == rs2);
	assign rs2_hz_ex  = regwrite_ex  && (rd_ex  == rs2);
	assign rs2_hz_mem = regwrite_mem && (rd_mem == rs2);
	assign rs2_hz_wb  = regwrite_wb  && (rd_wb  == rs2);

	assign rs1_hz_ex_noload  = rs1_hz_ex && !memread_ex;
	assign rs1_hz_mem_load   = rs1_hz_mem && memread_mem;
	assign rs1_hz_mem_noload = rs1_hz_mem && !memread_mem;
	assign rs2_hz_mem_load   = rs2_hz_mem && memread_mem;
	assign rs2_hz_mem_noload = rs2_hz_mem && !memread_mem;

	// MEM holds the younger value, so it wins over WB.
	assign rs1_fwd = rs1_hz_mem_noload ? FWD_MEM : (rs1_hz_wb ? FWD_WB : FWD_NONE);
	assign rs2_fwd = rs2_hz_mem_noload ? FWD_MEM : (rs2_hz_wb ? FWD_WB : FWD_NONE);

	assign b_type_prediction_en = b_type && (rs1_hz_id || rs2_hz_id || rs1_hz_ex || rs2_hz_ex ||
	                                         rs1_hz_mem_load || rs2_hz_mem_load);

	// A tracker at x0 means no copy of ra is live.
	assign is_ret   = (rs1 == `RA_REG) || ((ras_ra_track != `ZERO_REG) && (rs1 == ras_ra_track));
	assign rd_is_ra = rd == `RA_REG;

	assign jalr_prediction_en = jalr && is_ret && (rs1_hz_id || rs1_hz_ex || rs1_hz_mem_load);
	assign pl_stall_inner     = jalr && !is_ret && (rs1_hz_ex_noload || rs1_hz_mem_load);

	assign advance  = !pl_flush && !pl_stall && !pl_stall_inner;
	assign ras_push = advance && rd_is_ra && (jal || jalr);
	assign ras_pop  = advance && jalr && is_ret;

	// Undo the stack effect of whatever the flush kills in ID and EX.
	assign ras_rollback_pop_id  = pl_flush && !pl_stall && (rd_id == `RA_REG) &&
	                              (jal_id || jalr_id);
	assign ras_rollback_push_id = pl_flush && !pl_stall && pred_hist_id;
	assign ras_rollback_push_ex = pl_flush && !pl_stall && pred_hist_ex;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pred_hist_id <= 1'b0;
			pred_hist_ex <= 1'b0;
		end else if (!pl_stall) begin
			pred_hist_id <= jalr_prediction_en && !pl_flush;
			pred_hist_ex <= pred_hist_id && !pl_flush;
		end
	end

	assign wr_ra_track_en   = !pl_stall &&
	                          ((mv && (rs1 == `RA_REG) && (rd != `ZERO_REG)) || (sw && rd_is_ra));
	assign wr_ra_track_data = sw ? `ZERO_REG : rd; // A stored ra may be reloaded anywhere.

endmodule

`default_nettype wire

// File: hdl/pipe_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top import rv_ctrl_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] instr,
	input  logic [31:0] pc,
	input  logic        pl_flush,
	input  logic        pl_stall,
	output fwd_sel_t    rs1_fwd,
	output fwd_sel_t    rs2_fwd,
	output logic        b_type_prediction_en,
	output logic        jalr_prediction_en,
	output logic        pl_stall_inner,
	output logic [31:0] ras_target
);

	logic [4:0] rs1, rs2, rd;
	logic       regwrite, memread, b_type, jal, jalr, mv, sw;
	logic [4:0] rd_id, rd_ex, rd_mem, rd_wb;
	logic       regwrite_id, regwrite_ex, regwrite_mem, regwrite_wb;
	logic       memread_ex, memread_mem;
	logic       jal_id, jalr_id;
	logic       ras_push, ras_pop;
	logic       ras_rollback_pop_id, ras_rollback_push_id, ras_rollback_push_ex;
	logic       wr_ra_track_en;
	logic [4:0] wr_ra_track_data;
	logic [4:0] ras_ra_track;

	predecode u_predecode (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd),
		.regwrite(regwrite), .memread(memread), .b_type(b_type),
		.jal(jal), .jalr(jalr), .mv(mv), .sw(sw)
	);

	stage_track u_stage_track (
		.clk(clk), .rst_n(rst_n), .pl_stall(pl_stall),
		.pl_stall_inner(pl_stall_inner), .pl_flush(pl_flush),
		.rd_in(rd), .regwrite_in(regwrite), .memread_in(memread),
		.jal_in(jal), .jalr_in(jalr),
		.rd_id(rd_id), .rd_ex(rd_ex), .rd_mem(rd_mem), .rd_wb(rd_wb),
		.regwrite_id(regwrite_id), .regwrite_ex(regwrite_ex),
		.regwrite_mem(regwrite_mem), .regwrite_wb(regwrite_wb),
		.memread_ex(memread_ex), .memread_mem(memread_mem),
		.jal_id(jal_id), .jalr_id(jalr_id)
	);

	mini_control u_mini_control (
		.clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
		.rd_id(rd_id), .rd_ex(rd_ex), .rd_mem(rd_mem), .rd_wb(rd_wb),
		.regwrite_id(regwrite_id), .regwrite_ex(regwrite_ex),
		.regwrite_mem(regwrite_mem), .regwrite_wb(regwrite_wb),
		.memread_ex(memread_ex), .memread_mem(memread_mem),
		.jal_id(jal_id), .jalr_id(jalr_id), .b_type(b_type), .mv(mv), .sw(sw),
		.jal(jal), .jalr(jalr), .pl_flush(pl_flush), .pl_stall(pl_stall),
		.ras_ra_track(ras_ra_track), .rs1_fwd(rs1_fwd), .rs2_fwd(rs2_fwd),
		.b_type_prediction_en(b_type_prediction_en),
		.jalr_prediction_en(jalr_prediction_en), .pl_stall_inner(pl_stall_inner),
		.ras_push(ras_push), .ras_pop(ras_pop),
		.ras_rollback_pop_id(ras_rollback_pop_id),
		.ras_rollback_push_id(ras_rollback_push_id),
		.ras_rollback_push_ex(ras_rollback_push_ex),
		.wr_ra_track_en(wr_ra_track_en), .wr_ra_track_data(wr_ra_track_data)
	);

	return_stack u_return_stack (
		.clk(clk), .rst_n(rst_n), .pc(pc), .ras_push(ras_push), .ras_pop(ras_pop),
		.ras_rollback_pop_id(ras_rollback_pop_id),
		.ras_rollback_push_id(ras_rollback_push_id),
		.ras_rollback_push_ex(ras_rollback_push_ex),
		.wr_ra_track_en(wr_ra_track_en), .wr_ra_track_data(wr_ra_track_data),
		.ras_target(ras_target), .ras_ra_track(ras_ra_track)
	);

endmodule

`default_nettype wire

// File: hdl/predecode.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ctrl_params.svh"

module predecode import rv_ctrl_pkg::*; (
	input  instr_word_t instr,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2,
	output logic [4:0]  rd,
	output logic        regwrite,
	output logic        memread,
	output logic        b_type,
	output logic        jal,
	output logic        jalr,
	output logic        mv,
	output logic        sw
);

	logic [6:0] opcode;
	logic       is_load;
	logic       is_store;
	logic       is_branch;
	logic       is_jal;
	logic       is_jalr;
	logic       is_opimm;
	logic       is_op;
	logic       is_lui;
	logic       uses_rs1;
	logic       uses_rs2;

	assign opcode    = instr.r.opcode;
	assign is_load   = opcode == `OP_LOAD;
	assign is_store  = opcode == `OP_STORE;
	assign is_branch = opcode == `OP_BRANCH;
	assign is_jal    = opcode == `OP_JAL;
	assign is_jalr   = opcode == `OP_JALR;
	assign is_opimm  = opcode == `OP_OPIMM;
	assign is_op     = opcode == `OP_OP;
	assign is_lui    = opcode == `OP_LUI;

	// Unused source fields read as x0 so they never match a writer.
	assign uses_rs1 = !(is_jal || is_lui);
	assign uses_rs2 = is_op || is_store || is_branch;

	assign rs1 = uses_rs1 ? instr.i.rs1 : `ZERO_REG;
	assign rs2 = uses_rs2 ? instr.r.rs2 : `ZERO_REG;

	// A store reports its data register here so that a store of ra is visible.
	assign rd = is_store  ? instr.s.rs2 :
	            is_branch ? `ZERO_REG   : instr.i.rd;

	assign regwrite = (is_load || is_opimm || is_op || is_lui || is_jal || is_jalr) &&
	                  (rd != `ZERO_REG);
	assign memread  = is_load;
	assign b_type   = is_branch;
	assign jal      = is_jal;
	assign jalr     = is_jalr;
	assign sw       = is_store;

	// Register move, addi rd, rs1, 0.
	assign mv = is_opimm && (instr.i.funct3 == 3'b000) && (instr.i.imm == 12'd0);

endmodule

`default_nettype wire

// File: hdl/return_stack.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ctrl_params.svh"

module return_stack (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [31:0] pc,
	input  logic        ras_push,
	input  logic        ras_pop,
	input  logic        ras_rollback_pop_id,
	input  logic        ras_rollback_push_id,
	input  logic        ras_rollback_push_ex,
	input  logic        wr_ra_track_en,
	input  logic [4:0]  wr_ra_track_data,
	output logic [31:0] ras_target,
	output logic [4:0]  ras_ra_track
);

	localparam int PTR_W = $clog2(`RAS_DEPTH);

	logic [31:0]      ras_mem [`RAS_DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] top_idx;
	logic [PTR_W-1:0] push_idx;
	logic signed [3:0] ptr_delta;

	always_comb begin
		ptr_delta = 4'sd0;
		if (ras_push)
			ptr_delta = ptr_delta + 4'sd1;
		if (ras_pop)
			ptr_delta = ptr_delta - 4'sd1;
		if (ras_rollback_pop_id)
			ptr_delta = ptr_delta - 4'sd1;
		if (ras_rollback_push_id)
			ptr_delta = ptr_delta + 4'sd1;
		if (ras_rollback_push_ex)
			ptr_delta = ptr_delta + 4'sd1;
	end

	assign top_idx  = ptr - 1'b1;
	assign push_idx = ptr - {{(PTR_W-1){1'b0}}, ras_pop}; // Slot after a same-cycle pop.

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
		end else begin
			ptr <= ptr + ptr_delta[PTR_W-1:0]; // Wraps modulo the depth.
		end
	end

	// Popped entries stay in place so a rollback can bring them back.
	always_ff @(posedge clk) begin
		if (ras_push) begin
			ras_mem[push_idx] <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ras_ra_track <= 5'd0;
		end else if (wr_ra_track_en) begin
			ras_ra_track <= wr_ra_track_data;
		end
	end

	assign ras_target = ras_mem[top_idx];

endmodule

`default_nettype wire

// File: hdl/rv_ctrl_params.svh
`ifndef RV_CTRL_PARAMS_SVH
`define RV_CTRL_PARAMS_SVH

`define ZERO_REG   5'd0
`define RA_REG     5'd1 // Link register of the calling convention.
`define RAS_DEPTH  8    // Must be a power of two for the pointer wrap.

`define OP_LOAD    7'b0000011
`define OP_STORE   7'b0100011
`define OP_BRANCH  7'b1100011
`define OP_JAL     7'b1101111
`define OP_JALR    7'b1100111
`define OP_OPIMM   7'b0010011
`define OP_OP      7'b0110011
`define OP_LUI     7'b0110111

`endif

// File: hdl/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} j_fmt_t;

	// All views share the opcode, rd, rs1 and rs2 bit positions.
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		j_fmt_t j;
	} instr_word_t;

	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,
		FWD_WB   = 2'b01,
		FWD_MEM  = 2'b10
	} fwd_sel_t;

endpackage

`default_nettype wire

// File: hdl/stage_track.sv
`timescale 1ns/1ps
`default_nettype none

module stage_track (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       pl_stall,
	input  logic       pl_stall_inner,
	input  logic       pl_flush,
	input  logic [4:0] rd_in,
	input  logic       regwrite_in,
	input  logic       memread_in,
	input  logic       jal_in,
	input  logic       jalr_in,
	output logic [4:0] rd_id,
	output logic [4:0] rd_ex,
	output logic [4:0] rd_mem,
	output logic [4:0] rd_wb,
	output logic       regwrite_id,
	output logic       regwrite_ex,
	output logic       regwrite_mem,
	output logic       regwrite_wb,
	output logic       memread_ex,
	output logic       memread_mem,
	output logic       jal_id,
	output logic       jalr_id
);

	logic memread_id;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_id        <= 5'd0;
			rd_ex        <= 5'd0;
			rd_mem       <= 5'd0;
			rd_wb        <= 5'd0;
			regwrite_id  <= 1'b0;
			regwrite_ex  <= 1'b0;
			regwrite_mem <= 1'b0;
			regwrite_wb  <= 1'b0;
			memread_id   <= 1'b0;
			memread_ex   <= 1'b0;
			memread_mem  <= 1'b0;
			jal_id       <= 1'b0;
			jalr_id      <= 1'b0;
		end else if (!pl_stall) begin
			if (pl_flush || pl_stall_inner) begin // Bubble into ID.
				rd_id       <= 5'd0;
				regwrite_id <= 1'b0;
				memread_id  <= 1'b0;
				jal_id      <= 1'b0;
				jalr_id     <= 1'b0;
			end else begin
				rd_id       <= rd_in;
				regwrite_id <= regwrite_in;
				memread_id  <= memread_in;
				jal_id      <= jal_in;
				jalr_id     <= jalr_in;
			end
			rd_ex        <= pl_flush ? 5'd0 : rd_id;
			regwrite_ex  <= pl_flush ? 1'b0 : regwrite_id;
			memread_ex   <= pl_flush ? 1'b0 : memread_id;
			rd_mem       <= rd_ex;
			regwrite_mem <= regwrite_ex;
			memread_mem  <= memread_ex;
			rd_wb        <= rd_mem;
			regwrite_wb  <= regwrite_mem;
		end
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_pipe_ctrl -Mdir obj_dir -f flist.f

out=$(./obj_dir/Vtb_pipe_ctrl)
echo "$out"

if echo "$out" | grep -qx "Finished with no errors"; then
	exit 0
else
	exit 1
fi
